// ==== march_top.f ====
logic/march_pkg.sv
logic/ray_stepper.sv
logic/frame_buffer.sv
logic/scan_display.sv
logic/march_top.sv
tests/march_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --assert -Wno-fatal
TOP ?= march_tb
FILELIST ?= march_top.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir

// ==== tests/march_tb.sv ====
`timescale 1ns/1ps

module march_tb;

  localparam int LINE = march_pkg::H_TOTAL;
  localparam int FRAME = march_pkg::H_TOTAL * march_pkg::V_TOTAL;
  localparam int W = march_pkg::DISP_W;
  localparam int H = march_pkg::DISP_H;

  // sync windows on the raster counters
  localparam int HS_LO_FIRST = 18;
  localparam int HS_LO_LAST = 20;
  localparam int VS_LO_FIRST = 13;
  localparam int VS_LO_LAST = 14;

  // vs rises at the start of the row after its low window and row 0 follows the back rows
  localparam int FIRST_OFFSET = (march_pkg::V_TOTAL - 1 - VS_LO_LAST) * LINE;
  localparam int LAST_SAMPLE = FIRST_OFFSET + (H - 1) * LINE + W - 1;

  // worst case render time in display frames plus margin
  localparam int RENDER_FRAMES = (W * H * (march_pkg::MAX_STEPS + 2)) / FRAME + 2;

  logic clk_in;
  logic rst;
  march_pkg::vec3_t cam;
  march_pkg::vga_out_t vga;

  int errors;
  bit timed_out;
  int got [W * H];

  march_top DUT (
    .clk_in(clk_in),
    .rst(rst),
    .cam(cam),
    .vga(vga)
  );

  always #20 clk_in = ~clk_in;

  task automatic check(input string name, input int expected, input int actual);
    if (expected != actual) begin
      errors++;
      $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic abort_run(input string what);
    $display("ERROR: %s", what);
    errors++;
    timed_out = 1'b1;
    forever @(negedge clk_in);
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (2) @(negedge clk_in);
    rst = 1'b0;
  endtask

  task automatic wait_vs_rise();
    logic prev;
    bit found;
    int n;
    prev = vga.vs;
    found = 1'b0;
    n = 0;
    while (!found && n < 2 * FRAME) begin
      @(negedge clk_in);
      found = !prev && vga.vs;
      prev = vga.vs;
      n++;
    end
    if (!found) abort_run("no rising edge on vs within two frame periods");
  endtask

  task automatic wait_frames(input int count);
    repeat (count) wait_vs_rise();
  endtask

  // records the visible pixels of the next frame into got
  task automatic capture_frame();
    int n;
    int pos;
    wait_vs_rise();
    for (n = 0; n <= LAST_SAMPLE; n++) begin
      pos = n - FIRST_OFFSET;
      if (pos >= 0 && pos % LINE < W) begin
        got[(pos / LINE) * W + pos % LINE] = int'(vga.r);
      end
      @(negedge clk_in);
    end
  endtask

  // first sample within the radius sets the shade
  function automatic int model_pixel(march_pkg::vec3_t c, int row, int col);
    longint px;
    longint py;
    longint pz;
    longint dx;
    longint dy;
    int k;
    int color;
    bit found;
    color = 0;
    found = 1'b0;
    dx = (col - 8) * 16;
    dy = (row - 6) * 16;
    for (k = 0; k < march_pkg::MAX_STEPS && !found; k++) begin
      px = longint'(c.x) + k * dx;
      py = longint'(c.y) + k * dy;
      pz = longint'(c.z) + k * 256 - 8 * 256;
      if (px * px + py * py + pz * pz <= 9 * 65536) begin
        found = 1'b1;
        color = 15 - k;
      end
    end
    return color;
  endfunction

  task automatic compare_frame(input string name, input march_pkg::vec3_t c);
    int i;
    for (i = 0; i < W * H; i++) begin
      check($sformatf("%s pixel %0d", name, i), model_pixel(c, i / W, i % W), got[i]);
    end
  endtask

  task automatic hold_camera(input march_pkg::vec3_t c);
    cam = c;
    wait_frames(3 * RENDER_FRAMES);
  endtask

  task automatic check_idle_outputs(input string name);
    check({name, " hs"}, 1, int'(vga.hs));
    check({name, " vs"}, 1, int'(vga.vs));
    check({name, " r"}, 0, int'(vga.r));
    check({name, " g"}, 0, int'(vga.g));
    check({name, " b"}, 0, int'(vga.b));
  endtask

  task automatic reset_state();
    int i;
    check_idle_outputs("reset_state");
    capture_frame();
    for (i = 0; i < W * H; i++) begin
      check($sformatf("reset_state pixel %0d", i), 0, got[i]);
    end
  endtask

  task automatic sync_timing();
    march_pkg::vec3_t c;
    int n;
    int row;
    int col;
    int hs_low;
    int vs_low;
    bit vis;
    hs_low = 0;
    vs_low = 0;
    // camera at the sphere centre lights every visible pixel
    c = '0;
    c.z = march_pkg::fix_t'(8 * 256);
    hold_camera(c);
    wait_vs_rise();
    for (n = 0; n < FRAME; n++) begin
      row = (n / LINE + march_pkg::V_TOTAL - 1) % march_pkg::V_TOTAL;
      col = n % LINE;
      vis = row < H && col < W;
      check("sync_timing hs", int'(!(col >= HS_LO_FIRST && col <= HS_LO_LAST)), int'(vga.hs));
      check("sync_timing vs", int'(!(row >= VS_LO_FIRST && row <= VS_LO_LAST)), int'(vga.vs));
      check("sync_timing g", int'(vga.r), int'(vga.g));
      check("sync_timing b", int'(vga.r), int'(vga.b));
      if (!vis) begin
        check("sync_timing blank", 0, int'(vga.r));
      end else begin
        check("sync_timing lit", model_pixel(c, row, col), int'(vga.r));
      end
      hs_low += int'(!vga.hs);
      vs_low += int'(!vga.vs);
      @(negedge clk_in);
    end
    check("sync_timing hs low cycles", 3 * march_pkg::V_TOTAL, hs_low);
    check("sync_timing vs low cycles", 2 * LINE, vs_low);
    // next rising edge one full period later
    check("sync_timing period", 1, int'(vga.vs));
  endtask

  task automatic default_scene();
    march_pkg::vec3_t c;
    c = '0;
    hold_camera(c);
    capture_frame();
    compare_frame("default_scene", c);
  endtask

  task automatic moved_camera();
    march_pkg::vec3_t c;
    int i;
    for (i = 0; i < 3; i++) begin
      c.x = march_pkg::fix_t'(int'($urandom_range(1024)) - 512);
      c.y = march_pkg::fix_t'(int'($urandom_range(1024)) - 512);
      c.z = march_pkg::fix_t'(int'($urandom_range(768)));
      hold_camera(c);
      capture_frame();
      compare_frame($sformatf("moved_camera %0d", i), c);
    end
  endtask

  task automatic reset_mid_frame();
    march_pkg::vec3_t c;
    int i;
    c.x = march_pkg::fix_t'(256);
    c.y = march_pkg::fix_t'(-128);
    c.z = march_pkg::fix_t'(512);
    hold_camera(c);
    repeat (100) @(negedge clk_in);
    apply_reset();
    check_idle_outputs("reset_mid_frame");
    capture_frame();
    for (i = 0; i < W * H; i++) begin
      check($sformatf("reset_mid_frame black %0d", i), 0, got[i]);
    end
    wait_frames(2 * RENDER_FRAMES);
    capture_frame();
    compare_frame("reset_mid_frame", c);
  endtask

  // ends the run after a timeout
  initial begin
    wait (timed_out);
    $display("errors: %0d", errors);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    clk_in = 1'b0;
    rst = 1'b1;
    cam = '0;
    errors = 0;
    timed_out = 1'b0;
    void'($urandom(32'hbd61d084));
    apply_reset();
    reset_state();
    sync_timing();
    default_scene();
    moved_camera();
    reset_mid_frame();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== logic/march_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module march_top (
  input wire clk_in,
  input wire rst,
  input wire march_pkg::vec3_t cam,
  output march_pkg::vga_out_t vga
);

  march_pkg::pixel_wr_t pix;
  logic pix_valid;
  logic frame_done;
  logic ready;

  logic [march_pkg::ADDR_BITS-1:0] rd_addr;
  logic [3:0] rd_color;
  logic frame_start;

  ray_stepper ray_stepper_inst (
    .clk_in(clk_in),
    .rst(rst),
    .cam(cam),
    .ready(ready),
    .pix(pix),
    .pix_valid(pix_valid),
    .frame_done(frame_done)
  );

  frame_buffer frame_buffer_inst (
    .clk_in(clk_in),
    .rst(rst),
    .pix(pix),
    .pix_valid(pix_valid),
    .frame_done(frame_done),
    .frame_start(frame_start),
    .rd_addr(rd_addr),
    .ready(ready),
    .rd_color(rd_color)
  );

  scan_display scan_display_inst (
    .clk_in(clk_in),
    .rst(rst),
    .rd_color(rd_color),
    .rd_addr(rd_addr),
    .frame_start(frame_start),
    .vga(vga)
  );

endmodule

`default_nettype wire

// ==== logic/scan_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module scan_display (
  input wire clk_in,
  input wire rst,
  input wire [3:0] rd_color,
  output logic [march_pkg::ADDR_BITS-1:0] rd_addr,
  output logic frame_start,
  output march_pkg::vga_out_t vga
);

  typedef struct packed {
    logic vis;
    logic hs;
    logic vs;
  } timing_t;

  march_pkg::hcount_t col_cnt;
  march_pkg::vcount_t row_cnt;

  timing_t tim_raw;
  timing_t tim_d1;

  assign tim_raw.vis = (col_cnt < march_pkg::H_VIS) && (row_cnt < march_pkg::V_VIS);
  assign tim_raw.hs = !((col_cnt >= march_pkg::HS_START) && (col_cnt <= march_pkg::HS_END));
  assign tim_raw.vs = !((row_cnt >= march_pkg::VS_START) && (row_cnt <= march_pkg::VS_END));

  // row * 16 + column, only inside the visible area
  assign rd_addr = tim_raw.vis ? {row_cnt, col_cnt[3:0]} : '0;
  assign frame_start = (col_cnt == '0) && (row_cnt == '0);

  always_ff @(posedge clk_in) begin
    if (rst) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (col_cnt == march_pkg::H_LAST) begin
      col_cnt <= '0;
      if (row_cnt == march_pkg::V_LAST) begin
        row_cnt <= '0;
      end else begin
        row_cnt <= row_cnt + 1'b1;
      end
    end else begin
      col_cnt <= col_cnt + 1'b1;
    end
  end

  // first stage lines up with the memory read
  always_ff @(posedge clk_in) begin
    if (rst) begin
      tim_d1 <= '{vis: 1'b0, hs: 1'b1, vs: 1'b1};
    end else begin
      tim_d1 <= tim_raw;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      vga <= '{r: 4'd0, g: 4'd0, b: 4'd0, hs: 1'b1, vs: 1'b1};
    end else begin
      vga.r <= tim_d1.vis ? rd_color : 4'd0;
      vga.g <= tim_d1.vis ? rd_color : 4'd0;
      vga.b <= tim_d1.vis ? rd_color : 4'd0;
      vga.hs <= tim_d1.hs;
      vga.vs <= tim_d1.vs;
    end
  end

  counter_range_a: assert property (@(posedge clk_in) disable iff (rst)
    int'(col_cnt) < march_pkg::H_TOTAL && int'(row_cnt) < march_pkg::V_TOTAL);

endmodule

`default_nettype wire

// ==== logic/frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
  input wire clk_in,
  input wire rst,
  input wire march_pkg::pixel_wr_t pix,
  input wire pix_valid,
  input wire frame_done,
  input wire frame_start,
  input wire [march_pkg::ADDR_BITS-1:0] rd_addr,
  output logic ready,
  output logic [3:0] rd_color
);

  logic [3:0] mem0 [march_pkg::N_PIX];
  logic [3:0] mem1 [march_pkg::N_PIX];

  // front_sel low means mem0 is shown and mem1 is written
  logic front_sel;
  logic front_valid;
  logic swap_pending;

  logic wr_en;
  logic swap_now;
  logic rd_sel;
  logic rd_ok;

  assign wr_en = pix_valid && ready;
  assign swap_now = frame_start && swap_pending;

  // the read at frame_start already belongs to the new front buffer
  assign rd_sel = front_sel ^ swap_now;
  assign rd_ok = front_valid || swap_now;

  always_ff @(posedge clk_in) begin
    if (rst) begin
      front_sel <= 1'b0;
      front_valid <= 1'b0;
      swap_pending <= 1'b0;
      ready <= 1'b1;
    end else if (swap_now) begin
      front_sel <= ~front_sel;
      front_valid <= 1'b1;
      swap_pending <= 1'b0;
      ready <= 1'b1;
    end else if (frame_done) begin
      swap_pending <= 1'b1;
      ready <= 1'b0;
    end
  end

  always_ff @(posedge clk_in) begin
    if (wr_en) begin
      if (front_sel) begin
        mem0[pix.addr] <= pix.color;
      end else begin
        mem1[pix.addr] <= pix.color;
      end
    end
  end

  // black until the first finished frame is swapped in
  always_ff @(posedge clk_in) begin
    if (!rd_ok) begin
      rd_color <= 4'd0;
    end else if (rd_sel) begin
      rd_color <= mem1[rd_addr];
    end else begin
      rd_color <= mem0[rd_addr];
    end
  end

  no_write_pending_a: assert property (@(posedge clk_in) disable iff (rst)
    wr_en |-> !swap_pending);

  no_double_done_a: assert property (@(posedge clk_in) disable iff (rst)
    frame_done |-> !swap_pending);

endmodule

`default_nettype wire

// ==== logic/ray_stepper.sv ====
`timescale 1ns/1ps
`default_nettype none

module ray_stepper (
  input wire clk_in,
  input wire rst,
  input wire march_pkg::vec3_t cam,
  input wire ready,
  output march_pkg::pixel_wr_t pix,
  output logic pix_valid,
  output logic frame_done
);

  march_pkg::march_state_t state;
  logic [3:0] col;
  logic [3:0] row;
  logic [3:0] k;

  march_pkg::vec3_t cam_q;
  march_pkg::vec3_t pt;
  march_pkg::vec3_t dir;
  march_pkg::vec3_t dir_load;

  march_pkg::fix_t off_z;
  logic signed [31:0] sq_x;
  logic signed [31:0] sq_y;
  logic signed [31:0] sq_z;
  logic [33:0] dist_sq;

  logic first_pix;
  logic last_pix;
  logic hit;

  assign first_pix = (col == 4'd0) && (row == 4'd0);
  assign last_pix = (col == march_pkg::COL_LAST) && (row == march_pkg::ROW_LAST);

  // per-pixel step vector, z always advances by 1.0
  assign dir_load.x = march_pkg::fix_t'((int'(col) - march_pkg::COL_CENTER)
                                        * march_pkg::DIR_SCALE);
  assign dir_load.y = march_pkg::fix_t'((int'(row) - march_pkg::ROW_CENTER)
                                        * march_pkg::DIR_SCALE);
  assign dir_load.z = march_pkg::Z_STEP;

  // squared distance to the sphere centre at (0, 0, SPHERE_Z)
  assign off_z = pt.z - march_pkg::SPHERE_Z;
  assign sq_x = pt.x * pt.x;
  assign sq_y = pt.y * pt.y;
  assign sq_z = off_z * off_z;
  assign dist_sq = 34'(sq_x) + 34'(sq_y) + 34'(sq_z);
  assign hit = dist_sq <= 34'(march_pkg::RADIUS_SQ);

  assign frame_done = pix_valid && ready && last_pix;

  always_ff @(posedge clk_in) begin
    if (rst) begin
      state <= march_pkg::LOAD;
      col <= '0;
      row <= '0;
      pix_valid <= 1'b0;
    end else begin
      case (state)
        march_pkg::LOAD: begin
          state <= march_pkg::STEP;
        end
        march_pkg::STEP: begin
          if (hit || k == march_pkg::LAST_STEP) begin
            state <= march_pkg::WRITE;
            pix_valid <= 1'b1;
          end
        end
        march_pkg::WRITE: begin
          if (ready) begin
            pix_valid <= 1'b0;
            if (last_pix) begin
              col <= '0;
              row <= '0;
              state <= march_pkg::FRAME_WAIT;
            end else begin
              if (col == march_pkg::COL_LAST) begin
                col <= '0;
                row <= row + 4'd1;
              end else begin
                col <= col + 4'd1;
              end
              state <= march_pkg::LOAD;
            end
          end
        end
        march_pkg::FRAME_WAIT: begin
          // buffer holds ready low until the swap is done
          if (ready) begin
            state <= march_pkg::LOAD;
          end
        end
        default: state <= march_pkg::LOAD;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    case (state)
      march_pkg::LOAD: begin
        // one camera position per frame
        if (first_pix) begin
          cam_q <= cam;
        end
        pt <= first_pix ? cam : cam_q;
        dir <= dir_load;
        k <= '0;
      end
      march_pkg::STEP: begin
        pix.addr <= {row, col};
        if (hit) begin
          pix.color <= march_pkg::LAST_STEP - k;
        end else if (k == march_pkg::LAST_STEP) begin
          pix.color <= 4'd0;
        end else begin
          pt.x <= pt.x + dir.x;
          pt.y <= pt.y + dir.y;
          pt.z <= pt.z + dir.z;
          k <= k + 4'd1;
        end
      end
      default: begin
      end
    endcase
  end

  pix_hold_a: assert property (@(posedge clk_in) disable iff (rst)
    pix_valid && !ready |=> pix_valid && $stable(pix));

  done_in_write_a: assert property (@(posedge clk_in) disable iff (rst)
    frame_done |-> state == march_pkg::WRITE);

endmodule

`default_nettype wire

// ==== logic/march_pkg.sv ====
package march_pkg;

  // visible frame and pixel addressing
  localparam int DISP_W = 16;
  localparam int DISP_H = 12;
  localparam int N_PIX = DISP_W * DISP_H;
  localparam int ADDR_BITS = 8;

  // raster, including blanking
  localparam int H_TOTAL = 24;
  localparam int V_TOTAL = 16;
  localparam int H_BITS = 5;
  localparam int V_BITS = 4;

  typedef logic [H_BITS-1:0] hcount_t;
  typedef logic [V_BITS-1:0] vcount_t;

  localparam hcount_t H_VIS = hcount_t'(DISP_W);
  localparam hcount_t H_LAST = hcount_t'(H_TOTAL - 1);
  localparam hcount_t HS_START = hcount_t'(18);
  localparam hcount_t HS_END = hcount_t'(20);
  localparam vcount_t V_VIS = vcount_t'(DISP_H);
  localparam vcount_t V_LAST = vcount_t'(V_TOTAL - 1);
  localparam vcount_t VS_START = vcount_t'(13);
  localparam vcount_t VS_END = vcount_t'(14);

  // last column and row seen by the stepper
  localparam logic [3:0] COL_LAST = 4'(DISP_W - 1);
  localparam logic [3:0] ROW_LAST = 4'(DISP_H - 1);

  // Q8.8 scalars
  localparam int FRAC_BITS = 8;
  typedef logic signed [15:0] fix_t;

  localparam fix_t Z_STEP = fix_t'(1 << FRAC_BITS);
  localparam fix_t SPHERE_Z = fix_t'(8 << FRAC_BITS);
  // squared radius is Q16.16, same scale as a product of two Q8.8 values
  localparam logic [31:0] RADIUS_SQ = 32'(9 << (2 * FRAC_BITS));

  // ray direction spread around the frame centre
  localparam int COL_CENTER = 8;
  localparam int ROW_CENTER = 6;
  localparam int DIR_SCALE = 16;

  localparam int MAX_STEPS = 16;
  localparam logic [3:0] LAST_STEP = 4'(MAX_STEPS - 1);

  typedef struct packed {
    fix_t x;
    fix_t y;
    fix_t z;
  } vec3_t;

  typedef struct packed {
    logic [ADDR_BITS-1:0] addr;
    logic [3:0] color;
  } pixel_wr_t;

  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
    logic hs;
    logic vs;
  } vga_out_t;

  typedef enum logic [1:0] {
    LOAD,
    STEP,
    WRITE,
    FRAME_WAIT
  } march_state_t;

endpackage
